//--- common/core_pkg.sv
/*
 * Shared definitions for the N230 control core
 * Settings bus and readback widths, the setting register map,
 * readback selectors and the signature word fields
 */
package core_pkg;

   // ------------------------------------------------------------
   // Bus and datapath widths
   // ------------------------------------------------------------
   localparam int SET_ADDR_W   = 8;
   localparam int SET_DATA_W   = 32;
   localparam int RB_DATA_W    = 64;
   // One complex sample, I and Q packed
   localparam int SAMPLE_W     = 32;
   localparam int DELAY_W      = 5;
   localparam int RADIO_CTRL_W = 3;

   // ------------------------------------------------------------
   // Setting register map
   // ------------------------------------------------------------
   // One word per register, address 0 unused
   typedef enum logic [SET_ADDR_W-1:0] {
      SR_CORE_MISC          = 8'd1,
      SR_CORE_DATA_DELAY    = 8'd2,
      SR_CORE_CLK_DELAY     = 8'd3,
      SR_CORE_RADIO_CONTROL = 8'd4,
      SR_CORE_READBACK      = 8'd5,
      SR_CORE_GPSDO_ST      = 8'd6,
      SR_CORE_PPS_SEL       = 8'd7,
      SR_CORE_LOOPBACK      = 8'd8
   } set_addr_e;

   // ------------------------------------------------------------
   // Readback selectors
   // ------------------------------------------------------------
   // Values 5 to 7 read as zero
   typedef enum logic [2:0] {
      RB_CORE_SIGNATURE = 3'd0,
      RB_CORE_SPI       = 3'd1,
      RB_CORE_STATUS    = 3'd2,
      RB_CORE_BIST      = 3'd3,
      RB_CORE_GIT_HASH  = 3'd4
   } rb_sel_e;

   // Signature word fields
   localparam logic [31:0] SIGNATURE_MAGIC = 32'hACE0BA5E;
   localparam logic [7:0]  PRODUCT_ID      = 8'd2;
   localparam logic [7:0]  COMPAT_MAJOR    = 8'd1;
   localparam logic [15:0] COMPAT_MINOR    = 16'd0;

   // Clock delay tap starts mid range
   localparam logic [DELAY_W-1:0] CLK_DELAY_RESET = 5'd16;

endpackage

//--- common/core_ctrl_if.sv
/*
 * Setting register state shared by the control core blocks
 * Settings bank drives, front end and readback consume
 */
`timescale 1ns/1ps

interface core_ctrl_if;
   import core_pkg::*;

   // RX path takes TX samples when set
   logic       loopback;
   // PPS source, 0 internal, 1 external
   logic       pps_sel;
   // Readback word select
   rb_sel_e    rb_sel;
   // GPSDO status byte, host written
   logic [7:0] gpsdo_st;

   modport settings (output loopback, output pps_sel, output rb_sel, output gpsdo_st);
   modport frontend (input loopback, input pps_sel);
   modport readback (input rb_sel, input gpsdo_st);

endinterface

//--- logic/core_settings.sv
/*
 * Core setting register bank
 * Address decode of the settings bus, misc, delay tap, radio
 * control, readback select, PPS select and loopback registers
 */
`timescale 1ns/1ps

module core_settings (
   input  logic                               radio_clk,
   input  logic                               i_rst,
   // Settings bus, every strobe is a write
   input  logic                               i_set_stb,
   input  core_pkg::set_addr_e                i_set_addr,
   input  logic [core_pkg::SET_DATA_W-1:0]    i_set_data,
   // Register outputs
   output logic [core_pkg::SET_DATA_W-1:0]    o_misc_outs,
   output logic [core_pkg::DELAY_W-1:0]       o_data_delay,
   output logic                               o_ld_data_delay,
   output logic [core_pkg::DELAY_W-1:0]       o_clk_delay,
   output logic                               o_ld_clk_delay,
   output logic [core_pkg::RADIO_CTRL_W-1:0]  o_radio_control,
   core_ctrl_if.settings                      ctrl
);
   import core_pkg::*;

   // Per register write enables
   logic wr_misc;
   logic wr_data_delay;
   logic wr_clk_delay;
   logic wr_radio_control;
   logic wr_readback;
   logic wr_gpsdo_st;
   logic wr_pps_sel;
   logic wr_loopback;

   // ------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------
   // One hot, only while strobe is high
   always_comb begin
      wr_misc          = 1'b0;
      wr_data_delay    = 1'b0;
      wr_clk_delay     = 1'b0;
      wr_radio_control = 1'b0;
      wr_readback      = 1'b0;
      wr_gpsdo_st      = 1'b0;
      wr_pps_sel       = 1'b0;
      wr_loopback      = 1'b0;
      if (i_set_stb) begin
         case (i_set_addr)
            SR_CORE_MISC:          wr_misc          = 1'b1;
            SR_CORE_DATA_DELAY:    wr_data_delay    = 1'b1;
            SR_CORE_CLK_DELAY:     wr_clk_delay     = 1'b1;
            SR_CORE_RADIO_CONTROL: wr_radio_control = 1'b1;
            SR_CORE_READBACK:      wr_readback      = 1'b1;
            SR_CORE_GPSDO_ST:      wr_gpsdo_st      = 1'b1;
            SR_CORE_PPS_SEL:       wr_pps_sel       = 1'b1;
            SR_CORE_LOOPBACK:      wr_loopback      = 1'b1;
            // Unmapped address, write dropped
            default: ;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Register bank
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_misc_outs     <= '0;
         o_data_delay    <= '0;
         o_clk_delay     <= CLK_DELAY_RESET;
         o_radio_control <= '0;
         ctrl.rb_sel     <= RB_CORE_SIGNATURE;
         ctrl.pps_sel    <= 1'b0;
         ctrl.loopback   <= 1'b0;
      end else begin
         if (wr_misc)
            o_misc_outs <= i_set_data;
         // Delay taps take the low bits
         if (wr_data_delay)
            o_data_delay <= i_set_data[DELAY_W-1:0];
         if (wr_clk_delay)
            o_clk_delay <= i_set_data[DELAY_W-1:0];
         if (wr_radio_control)
            o_radio_control <= i_set_data[RADIO_CTRL_W-1:0];
         if (wr_readback)
            ctrl.rb_sel <= rb_sel_e'(i_set_data[2:0]);
         if (wr_pps_sel)
            ctrl.pps_sel <= i_set_data[0];
         if (wr_loopback)
            ctrl.loopback <= i_set_data[0];
      end
   end

   // ------------------------------------------------------------
   // Delay load strobes
   // ------------------------------------------------------------
   // One cycle after each write, same cycle the new tap shows up
   // Fires on rewrite of an unchanged value too
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_ld_data_delay <= 1'b0;
         o_ld_clk_delay  <= 1'b0;
      end else begin
         o_ld_data_delay <= wr_data_delay;
         o_ld_clk_delay  <= wr_clk_delay;
      end
   end

   // GPSDO status survives a core reset
   // Host software relies on the last reported lock state
   always_ff @(posedge radio_clk) begin
      if (wr_gpsdo_st)
         ctrl.gpsdo_st <= i_set_data[7:0];
   end

endmodule

//--- logic/core_readback.sv
/*
 * Registered 64-bit readback multiplexer
 * Signature, status, BIST and build hash words
 */
`timescale 1ns/1ps

module core_readback #(
   parameter logic [31:0] BUILD_HASH = 32'h0
) (
   input  logic                              radio_clk,
   input  logic                              i_rst,
   input  logic [31:0]                       i_rb_misc,
   input  logic                              i_bist_done,
   input  logic [1:0]                        i_bist_error,
   core_ctrl_if.readback                     ctrl,
   output logic [core_pkg::RB_DATA_W-1:0]    o_rb_data
);
   import core_pkg::*;

   logic [RB_DATA_W-1:0] rb_word;

   // ------------------------------------------------------------
   // Word select
   // ------------------------------------------------------------
   always_comb begin
      case (ctrl.rb_sel)
         // Magic, product and compat numbers
         RB_CORE_SIGNATURE:
            rb_word = {SIGNATURE_MAGIC, PRODUCT_ID, COMPAT_MAJOR, COMPAT_MINOR};
         // No SPI core here
         RB_CORE_SPI:
            rb_word = '0;
         // Radio status byte above gpsdo_st is always zero
         RB_CORE_STATUS:
            rb_word = {16'h0, 8'h0, ctrl.gpsdo_st, i_rb_misc};
         // External FIFO self test result
         RB_CORE_BIST:
            rb_word = {61'h0, i_bist_error, i_bist_done};
         // Abbreviated hash of the RTL source
         RB_CORE_GIT_HASH:
            rb_word = {32'h0, BUILD_HASH};
         default:
            rb_word = '0;
      endcase
   end

   // Output register, one cycle behind the selector
   always_ff @(posedge radio_clk) begin
      if (i_rst)
         o_rb_data <= '0;
      else
         o_rb_data <= rb_word;
   end

endmodule

//--- radio_frontend/radio_frontend.sv
/*
 * Radio side of the control core
 * PPS synchronizers with source select, RX/TX loopback
 */
`timescale 1ns/1ps

module radio_frontend (
   input  logic                            radio_clk,
   input  logic                            i_rst,
   // Raw PPS pulses, asynchronous
   input  logic                            i_pps_int,
   input  logic                            i_pps_ext,
   input  logic [core_pkg::SAMPLE_W-1:0]   i_rx0,
   input  logic [core_pkg::SAMPLE_W-1:0]   i_rx1,
   input  logic [core_pkg::SAMPLE_W-1:0]   i_tx0,
   input  logic [core_pkg::SAMPLE_W-1:0]   i_tx1,
   core_ctrl_if.frontend                   ctrl,
   output logic                            o_pps,
   output logic [core_pkg::SAMPLE_W-1:0]   o_rx0,
   output logic [core_pkg::SAMPLE_W-1:0]   o_rx1
);

   // Two flop chains, bit 1 is the safe stage
   logic [1:0] pps_int_sync;
   logic [1:0] pps_ext_sync;

   // ------------------------------------------------------------
   // PPS synchronizers
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         pps_int_sync <= 2'b00;
         pps_ext_sync <= 2'b00;
      end else begin
         pps_int_sync <= {pps_int_sync[0], i_pps_int};
         pps_ext_sync <= {pps_ext_sync[0], i_pps_ext};
      end
   end

   // Select after sync so a switch never sees a raw edge
   assign o_pps = ctrl.pps_sel ? pps_ext_sync[1] : pps_int_sync[1];

   // ------------------------------------------------------------
   // RX loopback
   // ------------------------------------------------------------
   // Sample registers, TX fed back while loopback is set
   always_ff @(posedge radio_clk) begin
      o_rx0 <= ctrl.loopback ? i_tx0 : i_rx0;
      o_rx1 <= ctrl.loopback ? i_tx1 : i_rx1;
   end

endmodule

//--- logic/n230_ctrl_core.sv
/*
 * N230 global control core, top level
 * Settings bank, readback mux and radio front end
 */
`timescale 1ns/1ps

module n230_ctrl_core #(
   parameter logic [31:0] BUILD_HASH = 32'h0
) (
   input  logic                               radio_clk,
   input  logic                               i_rst,
   // ------------------------------------------------------------
   // Settings bus
   // ------------------------------------------------------------
   input  logic                               i_set_stb,
   input  logic [core_pkg::SET_ADDR_W-1:0]    i_set_addr,
   input  logic [core_pkg::SET_DATA_W-1:0]    i_set_data,
   // ------------------------------------------------------------
   // Core settings
   // ------------------------------------------------------------
   output logic [core_pkg::SET_DATA_W-1:0]    o_misc_outs,
   output logic [core_pkg::DELAY_W-1:0]       o_data_delay,
   output logic                               o_ld_data_delay,
   output logic [core_pkg::DELAY_W-1:0]       o_clk_delay,
   output logic                               o_ld_clk_delay,
   output logic [core_pkg::RADIO_CTRL_W-1:0]  o_radio_control,
   // ------------------------------------------------------------
   // Readback
   // ------------------------------------------------------------
   input  logic [31:0]                        i_rb_misc,
   input  logic                               i_bist_done,
   input  logic [1:0]                         i_bist_error,
   output logic [core_pkg::RB_DATA_W-1:0]     o_rb_data,
   // ------------------------------------------------------------
   // Radio side
   // ------------------------------------------------------------
   input  logic                               i_pps_int,
   input  logic                               i_pps_ext,
   input  logic [core_pkg::SAMPLE_W-1:0]      i_rx0,
   input  logic [core_pkg::SAMPLE_W-1:0]      i_rx1,
   input  logic [core_pkg::SAMPLE_W-1:0]      i_tx0,
   input  logic [core_pkg::SAMPLE_W-1:0]      i_tx1,
   output logic                               o_pps,
   output logic [core_pkg::SAMPLE_W-1:0]      o_rx0,
   output logic [core_pkg::SAMPLE_W-1:0]      o_rx1
);
   import core_pkg::*;

   // Raw bus address seen as register map type
   set_addr_e set_addr;

   assign set_addr = set_addr_e'(i_set_addr);

   // Register state toward readback and front end
   core_ctrl_if ctrl_if ();

   core_settings settings_i (
      .radio_clk       (radio_clk),
      .i_rst           (i_rst),
      .i_set_stb       (i_set_stb),
      .i_set_addr      (set_addr),
      .i_set_data      (i_set_data),
      .o_misc_outs     (o_misc_outs),
      .o_data_delay    (o_data_delay),
      .o_ld_data_delay (o_ld_data_delay),
      .o_clk_delay     (o_clk_delay),
      .o_ld_clk_delay  (o_ld_clk_delay),
      .o_radio_control (o_radio_control),
      .ctrl            (ctrl_if.settings)
   );

   core_readback #(
      .BUILD_HASH (BUILD_HASH)
   ) readback_i (
      .radio_clk    (radio_clk),
      .i_rst        (i_rst),
      .i_rb_misc    (i_rb_misc),
      .i_bist_done  (i_bist_done),
      .i_bist_error (i_bist_error),
      .ctrl         (ctrl_if.readback),
      .o_rb_data    (o_rb_data)
   );

   radio_frontend frontend_i (
      .radio_clk (radio_clk),
      .i_rst     (i_rst),
      .i_pps_int (i_pps_int),
      .i_pps_ext (i_pps_ext),
      .i_rx0     (i_rx0),
      .i_rx1     (i_rx1),
      .i_tx0     (i_tx0),
      .i_tx1     (i_tx1),
      .ctrl      (ctrl_if.frontend),
      .o_pps     (o_pps),
      .o_rx0     (o_rx0),
      .o_rx1     (o_rx1)
   );

endmodule

//--- testbench/tb_checks.svh
/*
 * Output checks for the control core testbench
 * Mismatch report task and one concurrent assertion per output
 */

task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
   mismatch_count++;
   $display("MISMATCH time=%0t signal=%s expected=0x%h actual=0x%h",
            $time, sig, exp_v, act_v);
endtask

// ------------------------------------------------------------
// Setting registers and load pulses
// ------------------------------------------------------------
misc_ok: assert property (@(posedge radio_clk) chk_on |-> o_misc_outs == exp_misc)
   else report_mismatch("o_misc_outs", 64'($sampled(exp_misc)), 64'($sampled(o_misc_outs)));
data_delay_ok: assert property (@(posedge radio_clk) chk_on |-> o_data_delay == exp_data_delay)
   else report_mismatch("o_data_delay", 64'($sampled(exp_data_delay)),
                        64'($sampled(o_data_delay)));
clk_delay_ok: assert property (@(posedge radio_clk) chk_on |-> o_clk_delay == exp_clk_delay)
   else report_mismatch("o_clk_delay", 64'($sampled(exp_clk_delay)), 64'($sampled(o_clk_delay)));
radio_ctrl_ok: assert property (@(posedge radio_clk) chk_on |-> o_radio_control == exp_radio_ctrl)
   else report_mismatch("o_radio_control", 64'($sampled(exp_radio_ctrl)),
                        64'($sampled(o_radio_control)));
// Exactly one cycle per write
ld_data_ok: assert property (@(posedge radio_clk) chk_on |-> o_ld_data_delay == exp_ld_data)
   else report_mismatch("o_ld_data_delay", 64'($sampled(exp_ld_data)),
                        64'($sampled(o_ld_data_delay)));
ld_clk_ok: assert property (@(posedge radio_clk) chk_on |-> o_ld_clk_delay == exp_ld_clk)
   else report_mismatch("o_ld_clk_delay", 64'($sampled(exp_ld_clk)), 64'($sampled(o_ld_clk_delay)));

// ------------------------------------------------------------
// Readback and radio side
// ------------------------------------------------------------
rb_ok: assert property (@(posedge radio_clk) chk_on |-> o_rb_data == exp_rb_q)
   else report_mismatch("o_rb_data", $sampled(exp_rb_q), $sampled(o_rb_data));
pps_ok: assert property (@(posedge radio_clk) chk_on |-> o_pps == exp_pps)
   else report_mismatch("o_pps", 64'($sampled(exp_pps)), 64'($sampled(o_pps)));
rx0_ok: assert property (@(posedge radio_clk) chk_on |-> o_rx0 == exp_rx0)
   else report_mismatch("o_rx0", 64'($sampled(exp_rx0)), 64'($sampled(o_rx0)));
rx1_ok: assert property (@(posedge radio_clk) chk_on |-> o_rx1 == exp_rx1)
   else report_mismatch("o_rx1", 64'($sampled(exp_rx1)), 64'($sampled(o_rx1)));

//--- testbench/tb_n230_ctrl_core.sv
/*
 * Testbench for the N230 control core
 * Clock and reset, settings writes with a shadow register model,
 * random radio traffic, watchdog and closing report
 */
`timescale 1ns/1ps

module tb_n230_ctrl_core;
   import core_pkg::*;

   localparam int          CLK_PERIOD     = 100;
   localparam int          RESET_CYCLES   = 16;
   localparam logic [31:0] BUILD_HASH     = 32'h0F12ABCD;
   // Magic, product 2, compat 1.0
   localparam logic [63:0] SIGNATURE_WORD = 64'hACE0BA5E_0201_0000;
   // About 200 cycles of tests plus slack
   localparam int          TEST_CYCLES    = 220;
   localparam int          MARGIN_CYCLES  = 80;
   localparam int          WATCHDOG_NS    = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

   // DUT inputs
   logic        radio_clk = 1'b0;
   logic        i_rst;
   logic        i_set_stb;
   logic [7:0]  i_set_addr;
   logic [31:0] i_set_data;
   logic [31:0] i_rb_misc;
   logic        i_bist_done;
   logic [1:0]  i_bist_error;
   logic        i_pps_int;
   logic        i_pps_ext;
   logic [31:0] i_rx0, i_rx1, i_tx0, i_tx1;
   // DUT outputs
   logic [31:0] o_misc_outs;
   logic [4:0]  o_data_delay;
   logic        o_ld_data_delay;
   logic [4:0]  o_clk_delay;
   logic        o_ld_clk_delay;
   logic [2:0]  o_radio_control;
   logic [63:0] o_rb_data;
   logic        o_pps;
   logic [31:0] o_rx0, o_rx1;

   // Shadow registers, follow each issued write
   logic [31:0] exp_misc;
   logic [4:0]  exp_data_delay;
   logic [4:0]  exp_clk_delay;
   logic [2:0]  exp_radio_ctrl;
   logic [2:0]  exp_rb_sel;
   logic [7:0]  exp_gpsdo;
   logic        exp_pps_sel;
   logic        exp_loopback;
   // Expected values of the registered outputs
   logic [63:0] exp_rb_q;
   logic        exp_ld_data = 1'b0;
   logic        exp_ld_clk = 1'b0;
   logic [1:0]  pps_int_d;
   logic [1:0]  pps_ext_d;
   logic        exp_pps;
   logic [31:0] exp_rx0, exp_rx1;
   // Checks wait two edges past reset
   logic        chk_en = 1'b0;
   logic        chk_en2 = 1'b0;
   logic        chk_on;
   int          mismatch_count = 0;
   int          timeout_count = 0;

   `include "tb_checks.svh"

   always #(CLK_PERIOD / 2) radio_clk = ~radio_clk;

   n230_ctrl_core #(.BUILD_HASH(BUILD_HASH)) i_dut (
      .radio_clk (radio_clk), .i_rst (i_rst),
      .i_set_stb (i_set_stb), .i_set_addr (i_set_addr), .i_set_data (i_set_data),
      .o_misc_outs (o_misc_outs), .o_data_delay (o_data_delay),
      .o_ld_data_delay (o_ld_data_delay), .o_clk_delay (o_clk_delay),
      .o_ld_clk_delay (o_ld_clk_delay), .o_radio_control (o_radio_control),
      .i_rb_misc (i_rb_misc), .i_bist_done (i_bist_done), .i_bist_error (i_bist_error),
      .o_rb_data (o_rb_data), .i_pps_int (i_pps_int), .i_pps_ext (i_pps_ext),
      .i_rx0 (i_rx0), .i_rx1 (i_rx1), .i_tx0 (i_tx0), .i_tx1 (i_tx1),
      .o_pps (o_pps), .o_rx0 (o_rx0), .o_rx1 (o_rx1)
   );

   // Readback word predicted from selector and status inputs
   function automatic logic [63:0] expected_rb_word(input logic [2:0] sel,
         input logic [7:0] gps, input logic [31:0] misc, input logic done,
         input logic [1:0] err);
      logic [63:0] word;
      case (sel)
         3'd0:    word = SIGNATURE_WORD;
         3'd2:    word = {24'h0, gps, misc};
         3'd3:    word = {61'h0, err, done};
         3'd4:    word = {32'h0, BUILD_HASH};
         // SPI and selectors 5 to 7 read zero
         default: word = '0;
      endcase
      return word;
   endfunction

   // ------------------------------------------------------------
   // Reference pipeline
   // ------------------------------------------------------------
   always @(posedge radio_clk) begin
      exp_rb_q    <= expected_rb_word(exp_rb_sel, exp_gpsdo, i_rb_misc,
                                      i_bist_done, i_bist_error);
      exp_ld_data <= !i_rst && i_set_stb && (i_set_addr == SR_CORE_DATA_DELAY);
      exp_ld_clk  <= !i_rst && i_set_stb && (i_set_addr == SR_CORE_CLK_DELAY);
      pps_int_d   <= {pps_int_d[0], i_pps_int};
      pps_ext_d   <= {pps_ext_d[0], i_pps_ext};
      exp_rx0     <= exp_loopback ? i_tx0 : i_rx0;
      exp_rx1     <= exp_loopback ? i_tx1 : i_rx1;
      chk_en      <= !i_rst;
      chk_en2     <= !i_rst && chk_en;
   end

   assign exp_pps = exp_pps_sel ? pps_ext_d[1] : pps_int_d[1];
   assign chk_on  = chk_en2 && !i_rst;

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge radio_clk);
   endtask

   // One strobe cycle, shadow updated after the edge
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      i_set_stb  = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      @(negedge radio_clk);
      i_set_stb  = 1'b0;
      case (addr)
         SR_CORE_MISC:          exp_misc       = data;
         SR_CORE_DATA_DELAY:    exp_data_delay = data[4:0];
         SR_CORE_CLK_DELAY:     exp_clk_delay  = data[4:0];
         SR_CORE_RADIO_CONTROL: exp_radio_ctrl = data[2:0];
         SR_CORE_READBACK:      exp_rb_sel     = data[2:0];
         SR_CORE_GPSDO_ST:      exp_gpsdo      = data[7:0];
         SR_CORE_PPS_SEL:       exp_pps_sel    = data[0];
         SR_CORE_LOOPBACK:      exp_loopback   = data[0];
         default: ;
      endcase
   endtask

   // GPSDO status byte is not in the reset set
   task automatic apply_reset();
      i_rst          = 1'b1;
      i_set_stb      = 1'b0;
      exp_misc       = '0;
      exp_data_delay = '0;
      exp_clk_delay  = 5'd16;
      exp_radio_ctrl = '0;
      exp_rb_sel     = 3'd0;
      exp_pps_sel    = 1'b0;
      exp_loopback   = 1'b0;
      wait_cycles(RESET_CYCLES);
      i_rst = 1'b0;
   endtask

   task automatic close_run();
      $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   endtask

   // ------------------------------------------------------------
   // Radio side traffic, new values every falling edge
   // ------------------------------------------------------------
   initial begin
      logic [31:0] bits;
      i_pps_int    = 1'b0;
      i_pps_ext    = 1'b0;
      i_bist_done  = 1'b0;
      i_bist_error = 2'b00;
      i_rb_misc    = '0;
      i_rx0        = '0;
      i_rx1        = '0;
      i_tx0        = '0;
      i_tx1        = '0;
      forever begin
         @(negedge radio_clk);
         bits         = $urandom;
         i_pps_int    = bits[0];
         i_pps_ext    = bits[1];
         i_bist_done  = bits[2];
         i_bist_error = bits[4:3];
         i_rb_misc    = $urandom;
         i_rx0        = $urandom;
         i_rx1        = $urandom;
         i_tx0        = $urandom;
         i_tx1        = $urandom;
      end
   end

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial begin
      int          n;
      logic [31:0] rnd;
      logic [7:0]  addr;
      rnd        = $urandom(44);
      i_set_stb  = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      apply_reset();
      // Reset values and signature word
      wait_cycles(4);
      write_reg(SR_CORE_GPSDO_ST, $urandom);
      // Random writes, one in four to an unmapped address
      for (n = 0; n < 40; n++) begin
         rnd  = $urandom;
         addr = {5'd0, rnd[4:2]} + 8'd1;
         if (rnd[1:0] == 2'b00) begin
            addr = rnd[15:8];
            if (addr inside {[8'd1:8'd8]})
               addr = addr + 8'd8;
         end
         write_reg(addr, $urandom);
         if (rnd[5])
            wait_cycles(1);
      end
      write_reg(8'd0, 32'hFFFF_FFFF);
      write_reg(8'hFF, 32'hFFFF_FFFF);
      // Back to back rewrites of the same tap keep the pulse high
      write_reg(SR_CORE_DATA_DELAY, 32'd9);
      write_reg(SR_CORE_DATA_DELAY, 32'd9);
      wait_cycles(2);
      write_reg(SR_CORE_CLK_DELAY, 32'd21);
      write_reg(SR_CORE_CLK_DELAY, 32'd21);
      wait_cycles(2);
      // Every selector, status byte refreshed each time
      for (n = 0; n < 8; n++) begin
         write_reg(SR_CORE_GPSDO_ST, $urandom);
         write_reg(SR_CORE_READBACK, n);
         wait_cycles(3);
      end
      write_reg(SR_CORE_PPS_SEL, 32'd0);
      wait_cycles(8);
      write_reg(SR_CORE_PPS_SEL, 32'd1);
      wait_cycles(8);
      write_reg(SR_CORE_LOOPBACK, 32'd1);
      wait_cycles(8);
      write_reg(SR_CORE_LOOPBACK, 32'd0);
      wait_cycles(8);
      // Mid-run reset from non-default state
      write_reg(SR_CORE_MISC, $urandom);
      write_reg(SR_CORE_RADIO_CONTROL, 32'd5);
      write_reg(SR_CORE_CLK_DELAY, 32'd3);
      write_reg(SR_CORE_PPS_SEL, 32'd1);
      write_reg(SR_CORE_LOOPBACK, 32'd1);
      write_reg(SR_CORE_GPSDO_ST, 32'h5A);
      wait_cycles(2);
      apply_reset();
      wait_cycles(4);
      // Status word must still carry 5A
      write_reg(SR_CORE_READBACK, 32'd2);
      wait_cycles(4);
      close_run();
   end

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: test sequence did not complete within %0d ns", WATCHDOG_NS);
      timeout_count++;
      close_run();
   end

endmodule

//--- n230_ctrl_core.f
+incdir+testbench
common/core_pkg.sv
common/core_ctrl_if.sv
logic/core_settings.sv
logic/core_readback.sv
radio_frontend/radio_frontend.sv
logic/n230_ctrl_core.sv
testbench/tb_n230_ctrl_core.sv

//--- Makefile
# Verilator build and run for the N230 control core
VERILATOR ?= verilator
TOP       ?= tb_n230_ctrl_core
FILELIST  ?= n230_ctrl_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST)) testbench/tb_checks.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
